/* src/cpu_params.svh */
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

////////////////////////////////////////
// Memory geometry and timing
////////////////////////////////////////
`define CPU_MEM_ADDR_W   10    // 1024 words of main memory
`define CPU_MEM_LATENCY  4     // Cycles from enable to data_valid
`define CPU_NUM_REGS     8     // r0..r7, r0 hardwired to zero

////////////////////////////////////////
// Opcodes, bits 15..12 of the instruction
////////////////////////////////////////
`define CPU_OP_ADD  4'h0
`define CPU_OP_SUB  4'h1
`define CPU_OP_AND  4'h2
`define CPU_OP_XOR  4'h3
`define CPU_OP_LLB  4'h4  // Load sign-extended 8-bit immediate
`define CPU_OP_LW   4'h5
`define CPU_OP_SW   4'h6
`define CPU_OP_BZ   4'h7  // Branch if rd field register is zero
`define CPU_OP_HLT  4'hF
// Anything else executes as NOP

`endif

/* src/cpu_pkg.sv */
`default_nettype none

`include "cpu_params.svh"

package cpu_pkg;

  // Datapath word, also the pc and the instruction
  typedef logic [15:0] word_t;

  // Word address into main memory
  typedef logic [`CPU_MEM_ADDR_W-1:0] mem_addr_t;

  typedef logic [2:0] reg_idx_t;  // Register number
  typedef logic [3:0] opcode_t;   // Instruction bits 15..12

  // 0 add, 1 sub, 2 and, 3 xor, same as the low opcode bits
  typedef logic [1:0] alu_op_t;

  // Control sequencer states
  typedef enum logic [2:0] {
    ST_FETCH,       // Issue instruction read at pc
    ST_FETCH_WAIT,  // Wait for instruction word
    ST_EXECUTE,     // Decode and execute, one cycle
    ST_MEM_WAIT,    // LW or SW in flight
    ST_HALTED       // Parked until reset
  } ctrl_state_t;

endpackage

`default_nettype wire

/* src/cpu_ctrl.sv */
`timescale 1ns/10ps
`default_nettype none

`include "cpu_params.svh"

module cpu_ctrl import cpu_pkg::*; (
  input  wire     clk,
  input  wire     rst_n,
  input  wire     mem_data_valid,  // One-cycle completion from memory
  input  word_t   mem_data_out,    // Instruction or load data
  input  wire     zero,            // rd field register is zero
  output logic    mem_en,          // One-cycle request strobe
  output logic    mem_wr,
  output logic    addr_sel,        // 0 pc, 1 ALU result
  output word_t   instr,           // Instruction register
  output logic    rf_we,
  output logic    rf_wsel,         // 0 ALU, 1 memory data
  output alu_op_t alu_op,
  output logic    alu_use_imm,
  output logic    pc_inc,
  output logic    pc_branch,
  output logic    hlt
);

  ctrl_state_t state, state_nxt;
  opcode_t     opcode;
  logic        ir_load;

  assign opcode = instr[15:12];

  ////////////////////////////////////////
  // State, instruction and halt registers
  ////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= ST_FETCH;
      instr <= '0;
      hlt   <= 1'b0;
    end else begin
      state <= state_nxt;
      if (ir_load) instr <= mem_data_out;        // Latch on the data_valid cycle
      hlt <= (state_nxt == ST_HALTED);           // Rises the cycle after HLT executes
    end
  end

  ////////////////////////////////////////
  // Next state and strobes
  ////////////////////////////////////////
  always_comb begin
    state_nxt   = state;
    mem_en      = 1'b0;
    mem_wr      = 1'b0;
    addr_sel    = 1'b0;
    ir_load     = 1'b0;
    rf_we       = 1'b0;
    rf_wsel     = 1'b0;
    alu_op      = 2'b00;                         // Add unless an ALU op says otherwise
    alu_use_imm = 1'b0;
    pc_inc      = 1'b0;
    pc_branch   = 1'b0;
    unique case (state)
      ST_FETCH: begin
        mem_en    = 1'b1;                        // Read at pc
        state_nxt = ST_FETCH_WAIT;
      end
      ST_FETCH_WAIT: begin
        if (mem_data_valid) begin
          ir_load   = 1'b1;
          state_nxt = ST_EXECUTE;
        end
      end
      ST_EXECUTE: begin
        state_nxt = ST_FETCH;                    // Most ops finish here
        case (opcode)
          `CPU_OP_ADD, `CPU_OP_SUB, `CPU_OP_AND, `CPU_OP_XOR: begin
            alu_op = opcode[1:0];                // Opcode low bits pick the function
            rf_we  = 1'b1;
            pc_inc = 1'b1;
          end
          `CPU_OP_LLB: begin
            alu_use_imm = 1'b1;                  // ALU zeroes a, so result is the imm
            rf_we       = 1'b1;
            pc_inc      = 1'b1;
          end
          `CPU_OP_LW, `CPU_OP_SW: begin
            // Address is rs plus offset, issued straight from execute
            mem_en      = 1'b1;
            mem_wr      = (opcode == `CPU_OP_SW);
            addr_sel    = 1'b1;
            alu_use_imm = 1'b1;
            state_nxt   = ST_MEM_WAIT;
          end
          `CPU_OP_BZ: begin
            pc_branch = zero;                    // Taken
            pc_inc    = !zero;                   // Fall through
          end
          `CPU_OP_HLT: state_nxt = ST_HALTED;    // pc stays put
          default:     pc_inc = 1'b1;            // NOP and undefined opcodes
        endcase
      end
      ST_MEM_WAIT: begin
        addr_sel    = 1'b1;
        alu_use_imm = 1'b1;
        if (mem_data_valid) begin
          rf_we     = (opcode == `CPU_OP_LW);    // SW only needs the ack
          rf_wsel   = 1'b1;
          pc_inc    = 1'b1;
          state_nxt = ST_FETCH;
        end
      end
      ST_HALTED: state_nxt = ST_HALTED;          // Only reset leaves
      default:   state_nxt = ST_FETCH;
    endcase
  end

endmodule

`default_nettype wire

/* src/cpu_pc_unit.sv */
`timescale 1ns/10ps
`default_nettype none

module cpu_pc_unit import cpu_pkg::*; (
  input  wire   clk,
  input  wire   rst_n,
  input  word_t instr,      // BZ offset lives in bits 8..0
  input  wire   pc_inc,     // Step to pc+1
  input  wire   pc_branch,  // Jump to pc+1+offset
  output word_t pc
);

  word_t pc_plus1;
  word_t branch_off;

  assign pc_plus1   = pc + 16'd1;
  assign branch_off = {{7{instr[8]}}, instr[8:0]};  // Sign-extend 9-bit offset

  // Branch wins if both were ever raised
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc <= '0;                                // Programs start at word 0
    end else if (pc_branch) begin
      pc <= pc_plus1 + branch_off;
    end else if (pc_inc) begin
      pc <= pc_plus1;
    end
  end

  // Neither strobe: hold, which covers wait states and halt

endmodule

`default_nettype wire

/* src/cpu_regfile.sv */
`timescale 1ns/10ps
`default_nettype none

`include "cpu_params.svh"

module cpu_regfile import cpu_pkg::*; (
  input  wire      clk,
  input  wire      rst_n,
  input  reg_idx_t raddr_a,  // rs
  input  reg_idx_t raddr_b,  // rt, or rd field for BZ and SW
  output word_t    rdata_a,
  output word_t    rdata_b,
  input  wire      we,
  input  reg_idx_t waddr,
  input  word_t    wdata
);

  word_t regs [`CPU_NUM_REGS];

  // Writes to r0 are dropped so it keeps its reset zero
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < `CPU_NUM_REGS; i++) regs[i] <= '0;
    end else if (we && (waddr != '0)) begin
      regs[waddr] <= wdata;
    end
  end

  // Combinational reads, no bypass needed in a multi-cycle core
  assign rdata_a = regs[raddr_a];
  assign rdata_b = regs[raddr_b];

endmodule

`default_nettype wire

/* src/cpu_alu.sv */
`timescale 1ns/10ps
`default_nettype none

`include "cpu_params.svh"

module cpu_alu import cpu_pkg::*; (
  input  word_t   a,        // rs
  input  word_t   b,        // Port b register
  input  word_t   instr,
  input  alu_op_t alu_op,
  input  wire     use_imm,  // Second operand from instruction
  output word_t   result,
  output logic    zero      // For BZ, b holds the tested register
);

  opcode_t opcode;
  logic    is_llb;
  word_t   imm;
  word_t   op_a;
  word_t   op_b;

  assign opcode = instr[15:12];
  assign is_llb = (opcode == `CPU_OP_LLB);

  ////////////////////////////////////////
  // Immediate extraction
  ////////////////////////////////////////
  assign imm  = is_llb ? {{8{instr[7]}}, instr[7:0]}    // LLB value
                       : {{10{instr[5]}}, instr[5:0]};  // LW/SW offset
  assign op_a = is_llb ? '0 : a;                        // LLB passes imm through the adder
  assign op_b = use_imm ? imm : b;

  always_comb begin
    unique case (alu_op)
      2'b00:   result = op_a + op_b;
      2'b01:   result = op_a - op_b;
      2'b10:   result = op_a & op_b;
      default: result = op_a ^ op_b;
    endcase
  end

  assign zero = (b == '0);

endmodule

`default_nettype wire

/* src/memory4c.sv */
`timescale 1ns/10ps
`default_nettype none

`include "cpu_params.svh"

module memory4c import cpu_pkg::*; (
  input  wire       clk,
  input  wire       rst_n,
  input  wire       enable,      // One-cycle request
  input  wire       wr,          // 1 write, 0 read
  input  mem_addr_t addr,
  input  word_t     data_in,
  output logic      data_valid,  // Read data or write ack
  output word_t     data_out
);

  localparam int DEPTH = 1 << `CPU_MEM_ADDR_W;
  localparam int CNT_W = $clog2(`CPU_MEM_LATENCY + 1);

  word_t            mem_array [DEPTH];  // Testbench preloads this directly
  logic             busy;               // Request in flight
  logic [CNT_W-1:0] cnt;                // Cycles left before completion
  logic             fire;               // Last wait cycle
  logic             wr_q;
  mem_addr_t        addr_q;
  word_t            data_q;

  assign fire = busy && (cnt == CNT_W'(1));

  ////////////////////////////////////////
  // Latency counter
  ////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy       <= 1'b0;
      cnt        <= '0;
      data_valid <= 1'b0;
    end else begin
      data_valid <= fire;                              // Visible LATENCY cycles after enable
      if (fire) begin
        busy <= 1'b0;
      end else if (busy) begin
        cnt <= cnt - CNT_W'(1);
      end else if (enable) begin
        busy <= 1'b1;
        cnt  <= CNT_W'(`CPU_MEM_LATENCY - 1);
      end
    end
  end

  // Request capture, enable while busy is ignored
  always_ff @(posedge clk) begin
    if (enable && !busy) begin
      wr_q   <= wr;
      addr_q <= addr;
      data_q <= data_in;
    end
  end

  ////////////////////////////////////////
  // Storage, contents survive reset
  ////////////////////////////////////////
  always @(posedge clk) begin
    if (fire) begin
      if (wr_q) mem_array[addr_q] <= data_q;
      data_out <= mem_array[addr_q];                   // Old word on writes, ignored
    end
  end

endmodule

`default_nettype wire

/* src/cpu.sv */
`timescale 1ns/10ps
`default_nettype none

`include "cpu_params.svh"

module cpu import cpu_pkg::*; (
  input  wire   clk,
  input  wire   rst_n,
  output logic  hlt,   // High once HLT has executed
  output word_t pc     // Current instruction address
);

  ////////////////////////////////////////
  // Internal nets
  ////////////////////////////////////////
  logic      mem_en, mem_wr, mem_data_valid;
  mem_addr_t mem_addr;
  word_t     mem_data_out;
  logic      addr_sel;
  word_t     instr;
  opcode_t   opcode;
  logic      rf_we, rf_wsel;
  reg_idx_t  rf_raddr_b;
  word_t     rf_rdata_a, rf_rdata_b, rf_wdata;
  alu_op_t   alu_op;
  logic      alu_use_imm;
  word_t     alu_result;
  logic      zero;
  logic      pc_inc, pc_branch;

  assign opcode = instr[15:12];

  // BZ tests and SW stores the rd field register, everyone else reads rt
  assign rf_raddr_b = ((opcode == `CPU_OP_BZ) || (opcode == `CPU_OP_SW)) ? instr[11:9]
                                                                         : instr[5:3];
  assign rf_wdata = rf_wsel ? mem_data_out : alu_result;  // LW result or ALU

  // Fetch from pc, data access at rs plus offset
  assign mem_addr = addr_sel ? alu_result[`CPU_MEM_ADDR_W-1:0] : pc[`CPU_MEM_ADDR_W-1:0];

  cpu_ctrl u_ctrl (
    .clk(clk), .rst_n(rst_n),
    .mem_data_valid(mem_data_valid), .mem_data_out(mem_data_out), .zero(zero),
    .mem_en(mem_en), .mem_wr(mem_wr), .addr_sel(addr_sel), .instr(instr),
    .rf_we(rf_we), .rf_wsel(rf_wsel), .alu_op(alu_op), .alu_use_imm(alu_use_imm),
    .pc_inc(pc_inc), .pc_branch(pc_branch), .hlt(hlt)
  );

  cpu_pc_unit u_pc (
    .clk(clk), .rst_n(rst_n), .instr(instr),
    .pc_inc(pc_inc), .pc_branch(pc_branch), .pc(pc)
  );

  cpu_regfile u_rf (
    .clk(clk), .rst_n(rst_n),
    .raddr_a(instr[8:6]), .raddr_b(rf_raddr_b),    // rs and port b
    .rdata_a(rf_rdata_a), .rdata_b(rf_rdata_b),
    .we(rf_we), .waddr(instr[11:9]), .wdata(rf_wdata)
  );

  cpu_alu u_alu (
    .a(rf_rdata_a), .b(rf_rdata_b), .instr(instr), .alu_op(alu_op),
    .use_imm(alu_use_imm), .result(alu_result), .zero(zero)
  );

  // Shared instruction and data memory
  memory4c u_main_mem (
    .clk(clk), .rst_n(rst_n),
    .enable(mem_en), .wr(mem_wr), .addr(mem_addr),
    .data_in(rf_rdata_b),                            // SW data register
    .data_valid(mem_data_valid), .data_out(mem_data_out)
  );

endmodule

`default_nettype wire

/* sim/cpu_assertions.sv */
`timescale 1ns/10ps
`default_nettype none

`include "cpu_params.svh"

module cpu_assertions import cpu_pkg::*; (
  input wire   clk,
  input wire   rst_n,
  input wire   mem_en,          // Request strobe from the control unit
  input wire   mem_data_valid,
  input wire   hlt,
  input word_t r0               // Register file entry 0
);

  ////////////////////////////////////////
  // Memory protocol
  ////////////////////////////////////////
  a_valid_after_en: assert property (@(posedge clk) disable iff (!rst_n)
    mem_en |-> ##(`CPU_MEM_LATENCY) mem_data_valid)
    else $error("data_valid missing %0d cycles after enable", `CPU_MEM_LATENCY);

  // No completion without a request LATENCY cycles back
  a_no_stray_valid: assert property (@(posedge clk) disable iff (!rst_n)
    mem_data_valid |-> $past(mem_en, `CPU_MEM_LATENCY))
    else $error("data_valid without a matching enable");

  a_no_overlap: assert property (@(posedge clk) disable iff (!rst_n)
    mem_en |=> !mem_en [*(`CPU_MEM_LATENCY - 1)])  // Memory busy until the ack
    else $error("enable raised while an access is pending");

  ////////////////////////////////////////
  // Halt and r0
  ////////////////////////////////////////
  a_hlt_sticky: assert property (@(posedge clk) disable iff (!rst_n) hlt |=> hlt)
    else $error("hlt fell without reset");

  a_r0_zero: assert property (@(posedge clk) disable iff (!rst_n) r0 == '0)
    else $error("register 0 holds a nonzero value");

endmodule

`default_nettype wire

/* sim/cpu_tb.sv */
`timescale 1ns/10ps
`default_nettype none

`include "cpu_params.svh"

module cpu_tb import cpu_pkg::*; ();

  localparam int MEM_WORDS    = 1 << `CPU_MEM_ADDR_W;
  localparam int NUM_RUNS     = 20;
  localparam int PRO_LEN      = 12;                      // Base setup plus register seeds
  localparam int PROG_LEN     = PRO_LEN + 40 + 1;        // Body of 40 then HLT
  localparam int STEP_TIMEOUT = 2000;
  localparam int DATA_LO      = 512;
  localparam int DATA_HI      = 575;

  logic  clk;
  logic  rst_n;
  word_t pc;
  logic  hlt;
  word_t init_mem  [MEM_WORDS];                          // Image loaded into the DUT
  word_t model_mem [MEM_WORDS];                          // Reference memory
  word_t exp_pc [$];                                     // pc after each instruction
  bit    exp_bz [$];                                     // That instruction was a BZ
  word_t exp_halt_pc;
  int    check_errors;
  int    timeout_errors;

  cpu u_dut (.clk(clk), .rst_n(rst_n), .hlt(hlt), .pc(pc));

  bind cpu cpu_assertions u_assertions (
    .clk(clk), .rst_n(rst_n), .mem_en(mem_en), .mem_data_valid(mem_data_valid),
    .hlt(hlt), .r0(u_rf.regs[0])
  );

  always #2 clk = ~clk;                                  // 4 ns period

  //////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////
  function automatic word_t sign_extend(input word_t v, input int bits);
    return word_t'($signed(v << (16 - bits)) >>> (16 - bits));
  endfunction

  function automatic logic [7:0] rand_imm8();
    return ($urandom % 4 == 0) ? 8'h00 : 8'($urandom);  // Zeros feed BZ
  endfunction

  task automatic check_word(input string name, input word_t exp, input word_t act);
    assert (exp === act) else begin
      check_errors++;
      $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  // Wait for the next pc change or for hlt when want_halt is set
  task automatic wait_step(input word_t old_pc, input bit want_halt, output bit ok);
    int n;
    n  = 0;
    ok = 1'b0;
    while (!ok && n < STEP_TIMEOUT) begin
      @(negedge clk);
      n++;
      ok = want_halt ? hlt : ((pc !== old_pc) || hlt);
    end
  endtask

  //////////////////////////////////////////
  // Random program and data image
  //////////////////////////////////////////
  task automatic build_program();
    int       kind;
    int       off;
    reg_idx_t rd;
    for (int a = 0; a < MEM_WORDS; a++) init_mem[a] = 16'hF000 | word_t'(a);  // Stray fetch halts
    init_mem[0] = {`CPU_OP_LLB, 3'd7, 9'd64};                 // r7 = 64
    for (int i = 1; i <= 3; i++) init_mem[i] = {`CPU_OP_ADD, 3'd7, 3'd7, 3'd7, 3'd0};
    init_mem[4] = {`CPU_OP_LLB, 3'd6, 9'd32};
    init_mem[5] = {`CPU_OP_ADD, 3'd7, 3'd7, 3'd6, 3'd0};      // r7 = 544 mid data window
    for (int r = 1; r <= 6; r++) init_mem[5 + r] = {`CPU_OP_LLB, 3'(r), 1'b0, rand_imm8()};
    for (int i = PRO_LEN; i < PROG_LEN - 1; i++) begin
      kind = $urandom % 10;
      rd   = 3'($urandom % 7);                                // r7 never overwritten
      case (kind)
        0, 1, 2, 3: init_mem[i] = {2'b00, 2'($urandom), rd, 9'($urandom)};
        4:          init_mem[i] = {`CPU_OP_LLB, rd, 1'b0, rand_imm8()};
        5, 6:       init_mem[i] = {`CPU_OP_LW, rd, 3'd7, 6'($urandom)};
        7:          init_mem[i] = {`CPU_OP_SW, 3'($urandom), 3'd7, 6'($urandom)};
        8: begin
          off = $urandom % 4;
          if (off > PROG_LEN - 2 - i) off = PROG_LEN - 2 - i;   // Stay at or before HLT
          init_mem[i] = {`CPU_OP_BZ, 3'($urandom), 9'(off)};
        end
        default:    init_mem[i] = {4'(8 + $urandom % 7), 12'($urandom)};  // Undefined opcode
      endcase
    end
    init_mem[PROG_LEN - 1] = {`CPU_OP_HLT, 12'h000};
    for (int a = DATA_LO; a <= DATA_HI; a++) init_mem[a] = 16'($urandom);
  endtask

  //////////////////////////////////////////
  // Reference instruction model
  //////////////////////////////////////////
  task automatic run_model();
    word_t     r [8];
    word_t     p, ins, a, b, d, res, nxt;
    mem_addr_t addr;
    opcode_t   op;
    bit        done;
    int        steps;
    for (int i = 0; i < 8; i++) r[i] = '0;
    exp_pc.delete();
    exp_bz.delete();
    p     = '0;
    done  = 1'b0;
    steps = 0;
    while (!done && steps < 1000) begin
      ins  = model_mem[p[`CPU_MEM_ADDR_W-1:0]];
      op   = ins[15:12];
      a    = r[ins[8:6]];                                     // rs
      b    = r[ins[5:3]];                                     // rt
      d    = r[ins[11:9]];                                    // rd field
      addr = mem_addr_t'(a + sign_extend(ins, 6));
      nxt  = p + 16'd1;
      res  = '0;
      case (op)
        `CPU_OP_ADD: res = a + b;
        `CPU_OP_SUB: res = a - b;
        `CPU_OP_AND: res = a & b;
        `CPU_OP_XOR: res = a ^ b;
        `CPU_OP_LLB: res = sign_extend(ins, 8);
        `CPU_OP_LW:  res = model_mem[addr];
        `CPU_OP_SW:  model_mem[addr] = d;
        `CPU_OP_BZ:  if (d == '0) nxt = p + 16'd1 + sign_extend(ins, 9);
        `CPU_OP_HLT: done = 1'b1;
        default: ;                                            // NOP
      endcase
      if ((op <= `CPU_OP_LW) && (ins[11:9] != 3'd0)) r[ins[11:9]] = res;  // ADD..LW write rd
      if (done) begin
        exp_halt_pc = p;
      end else begin
        exp_pc.push_back(nxt);
        exp_bz.push_back(op == `CPU_OP_BZ);
        p = nxt;
      end
      steps++;
    end
  endtask

  //////////////////////////////////////////
  // Runs
  //////////////////////////////////////////
  initial begin
    bit    ok;
    bit    aborted;
    word_t last_pc;
    string name;
    clk            = 1'b0;
    rst_n          = 1'b0;
    check_errors   = 0;
    timeout_errors = 0;
    void'($urandom(71104));
    for (int run = 0; run < NUM_RUNS; run++) begin
      @(negedge clk);
      rst_n = 1'b0;
      build_program();
      for (int a = 0; a < MEM_WORDS; a++) begin
        u_dut.u_main_mem.mem_array[a] = init_mem[a];        // Preload under reset
        model_mem[a] = init_mem[a];
      end
      run_model();
      repeat (16) begin
        @(negedge clk);
        check_word("reset_hlt", '0, word_t'(hlt));
        check_word("reset_pc", '0, pc);
      end
      rst_n = 1'b1;
      @(negedge clk);
      check_word("post_reset_hlt", '0, word_t'(hlt));
      check_word("post_reset_pc", '0, pc);
      aborted = 1'b0;
      last_pc = '0;
      for (int s = 0; s < exp_pc.size() && !aborted; s++) begin
        wait_step(last_pc, 1'b0, ok);
        if (!ok) begin
          timeout_errors++;
          $display("ERROR: run %0d, pc stuck at %h for %0d cycles", run, last_pc, STEP_TIMEOUT);
          aborted = 1'b1;
        end else begin
          name = exp_bz[s] ? "branch_target" : "next_pc";
          check_word(name, exp_pc[s], pc);
          aborted = (pc !== exp_pc[s]);                     // Later steps are noise once pc diverges
          last_pc = pc;
        end
      end
      if (!aborted) begin
        wait_step(last_pc, 1'b1, ok);
        if (!ok) begin
          timeout_errors++;
          $display("ERROR: run %0d, hlt never rose within %0d cycles", run, STEP_TIMEOUT);
        end else begin
          check_word("halt_pc", exp_halt_pc, pc);
          repeat (50) begin
            @(negedge clk);
            check_word("halt_hold", 16'd1, word_t'(hlt));
            check_word("halt_pc_frozen", exp_halt_pc, pc);
          end
          for (int a = DATA_LO; a <= DATA_HI; a++)
            check_word("data_mem", model_mem[a], u_dut.u_main_mem.mem_array[a]);
        end
      end
    end
    $display("Summary: %0d check errors, %0d timeouts", check_errors, timeout_errors);
    if (check_errors == 0 && timeout_errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* cpu.f */
+incdir+src
src/cpu_pkg.sv
src/cpu_ctrl.sv
src/cpu_pc_unit.sv
src/cpu_regfile.sv
src/cpu_alu.sv
src/memory4c.sv
src/cpu.sv
sim/cpu_assertions.sv
sim/cpu_tb.sv
